/* common/gather_pkg.sv */
// gather engine
// line geometry and lane counts
`default_nettype none

package gather_pkg;

	// lanes and pixel width
	localparam int PORT_NUM   = 4;
	localparam int DATA_WIDTH = 16;

	// ------------------------------------------------------------------
	// line geometry
	// ------------------------------------------------------------------
	localparam int LINE_SIZE = 10;

	// rounded up, so the last lane gets the remainder
	localparam int UNIT_SIZE = (LINE_SIZE + (PORT_NUM - 1)) / PORT_NUM;

	// ------------------------------------------------------------------
	// counter widths
	// ------------------------------------------------------------------
	localparam int SEL_WIDTH        = 2;
	localparam int UNIT_COUNT_WIDTH = 2;
	localparam int LINE_COUNT_WIDTH = 4;

endpackage

`default_nettype wire

/* common/lane_pkg.sv */
// lane parameters
`default_nettype none

package lane_pkg;

	// gain word, one multiplier step per bit
	localparam int GAIN_WIDTH       = 8;
	localparam int MULT_COUNT_WIDTH = 4;

	// result FIFO per lane
	localparam int FIFO_DEPTH       = 4;
	localparam int FIFO_PTR_WIDTH   = 2;
	localparam int FIFO_COUNT_WIDTH = FIFO_PTR_WIDTH + 1;

endpackage

`default_nettype wire

/* verilog/line_ctrl.sv */
// unit and line counters
`timescale 1ns/1ps
`default_nettype none

module line_ctrl import gather_pkg::*; (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 in_fire,
	input  logic                 gather_fire,
	output logic [SEL_WIDTH-1:0] scatter_sel,
	output logic [SEL_WIDTH-1:0] gather_sel,
	output logic                 gather_last
);

	// set 0 follows the scatter side, set 1 the gather side
	logic [1:0]                  strobe;
	logic [SEL_WIDTH-1:0]        sel        [2];
	logic [UNIT_COUNT_WIDTH-1:0] unit_count [2];
	logic [LINE_COUNT_WIDTH-1:0] line_count [2];

	assign strobe = {gather_fire, in_fire};

	// ------------------------------------------------------------------
	// counter sets
	// ------------------------------------------------------------------
	for (genvar k = 0; k < 2; k++) begin : g_set
		logic unit_end;
		logic line_end;

		assign unit_end = unit_count[k] == UNIT_COUNT_WIDTH'(UNIT_SIZE - 1);
		assign line_end = line_count[k] == LINE_COUNT_WIDTH'(LINE_SIZE - 1);

		always_ff @(posedge clk) begin
			if (reset) begin
				sel[k]        <= '0;
				unit_count[k] <= '0;
				line_count[k] <= '0;
			end else if (strobe[k]) begin
				if (line_end) begin
					// back to lane 0 for the next line
					sel[k]        <= '0;
					unit_count[k] <= '0;
					line_count[k] <= '0;
				end else begin
					line_count[k] <= line_count[k] + 1'b1;
					if (unit_end) begin
						sel[k]        <= sel[k] + 1'b1;
						unit_count[k] <= '0;
					end else begin
						unit_count[k] <= unit_count[k] + 1'b1;
					end
				end
			end
		end
	end

	assign scatter_sel = sel[0];
	assign gather_sel  = sel[1];

	// head of the selected FIFO closes the line
	assign gather_last = line_count[1] == LINE_COUNT_WIDTH'(LINE_SIZE - 1);

endmodule

`default_nettype wire

/* verilog/line_scatter.sv */
// input stream scatter
`timescale 1ns/1ps
`default_nettype none

module line_scatter import gather_pkg::*; (
	input  logic [DATA_WIDTH-1:0] in_data,
	input  logic                  in_valid,
	output logic                  in_ready,
	output logic                  in_fire,
	input  logic [SEL_WIDTH-1:0]  scatter_sel,
	output logic [DATA_WIDTH-1:0] lane_in_data,
	output logic [PORT_NUM-1:0]   lane_in_valid,
	input  logic [PORT_NUM-1:0]   lane_in_ready
);

	// data fans out to every lane, only valid is steered
	assign lane_in_data = in_data;

	assign lane_in_valid = {{(PORT_NUM - 1){1'b0}}, in_valid} << scatter_sel;

	// ready comes back from the selected lane only
	assign in_ready = lane_in_ready[scatter_sel];

	assign in_fire = in_valid && in_ready;

endmodule

`default_nettype wire

/* lane/lane_mult.sv */
// serial gain multiplier
`timescale 1ns/1ps
`default_nettype none

module lane_mult import gather_pkg::*, lane_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [DATA_WIDTH-1:0] in_data,
	input  logic                  in_valid,
	input  logic [GAIN_WIDTH-1:0] gain,
	output logic                  in_ready,
	output logic [DATA_WIDTH-1:0] out_data,
	output logic                  out_valid,
	input  logic                  out_ready
);

	logic                        busy;
	logic [MULT_COUNT_WIDTH-1:0] bit_count;
	logic                        accept;
	logic                        staging;
	logic [DATA_WIDTH-1:0]       mcand;
	logic [GAIN_WIDTH-1:0]       mplier;
	logic [DATA_WIDTH-1:0]       acc;

	// one item at a time, taken only when fully idle
	assign in_ready = !busy && !out_valid;
	assign accept   = in_valid && in_ready;

	// all gain bits consumed
	assign staging = busy && (bit_count == MULT_COUNT_WIDTH'(GAIN_WIDTH));

	// ------------------------------------------------------------------
	// control
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			busy      <= 1'b0;
			bit_count <= '0;
			out_valid <= 1'b0;
		end else begin
			if (accept) begin
				busy      <= 1'b1;
				bit_count <= '0;
			end else if (staging) begin
				busy      <= 1'b0;
				out_valid <= 1'b1;
			end else if (busy) begin
				bit_count <= bit_count + 1'b1;
			end

			if (out_valid && out_ready) begin
				out_valid <= 1'b0;
			end
		end
	end

	// ------------------------------------------------------------------
	// shift-add datapath
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (accept) begin
			mcand  <= in_data;
			mplier <= gain;
			acc    <= '0;
		end else if (busy && !staging) begin
			// high bits fall off, which gives the truncated product
			if (mplier[0]) begin
				acc <= acc + mcand;
			end
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end

		if (staging) begin
			out_data <= acc;
		end
	end

endmodule

`default_nettype wire

/* lane/lane_fifo.sv */
// lane result FIFO, first word fall through
`timescale 1ns/1ps
`default_nettype none

module lane_fifo import gather_pkg::*, lane_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [DATA_WIDTH-1:0] in_data,
	input  logic                  in_valid,
	output logic                  in_ready,
	output logic [DATA_WIDTH-1:0] out_data,
	output logic                  out_valid,
	input  logic                  out_ready
);

	logic [DATA_WIDTH-1:0]       mem [FIFO_DEPTH];
	logic [FIFO_PTR_WIDTH-1:0]   wr_ptr;
	logic [FIFO_PTR_WIDTH-1:0]   rd_ptr;
	logic [FIFO_COUNT_WIDTH-1:0] count;
	logic                        full;
	logic                        wr_en;
	logic                        rd_en;

	assign full = count == FIFO_COUNT_WIDTH'(FIFO_DEPTH);

	// a read in the same cycle frees the slot
	assign in_ready  = !full || out_ready;
	assign out_valid = count != '0;
	assign out_data  = mem[rd_ptr];

	assign wr_en = in_valid && in_ready;
	assign rd_en = out_valid && out_ready;

	// storage
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= in_data;
		end
	end

	// ------------------------------------------------------------------
	// pointers and occupancy
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end

			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/data_gather.sv */
// lane gather and output register
`timescale 1ns/1ps
`default_nettype none

module data_gather import gather_pkg::*; (
	input  logic                           clk,
	input  logic                           reset,
	input  logic [PORT_NUM*DATA_WIDTH-1:0] fifo_data,
	input  logic [PORT_NUM-1:0]            fifo_valid,
	output logic [PORT_NUM-1:0]            fifo_ready,
	input  logic [SEL_WIDTH-1:0]           gather_sel,
	input  logic                           gather_last,
	output logic                           gather_fire,
	output logic [DATA_WIDTH-1:0]          out_data,
	output logic                           out_valid,
	output logic                           out_last,
	input  logic                           out_ready
);

	logic [DATA_WIDTH-1:0] head_data;
	logic                  head_valid;
	logic                  load_en;

	// ------------------------------------------------------------------
	// head select
	// ------------------------------------------------------------------
	assign head_data  = fifo_data[gather_sel*DATA_WIDTH +: DATA_WIDTH];
	assign head_valid = fifo_valid[gather_sel];

	// output stage takes a word when empty or draining
	assign load_en = !out_valid || out_ready;

	// only the selected lane sees ready
	assign fifo_ready = {{(PORT_NUM - 1){1'b0}}, load_en} << gather_sel;

	assign gather_fire = head_valid && load_en;

	// ------------------------------------------------------------------
	// output register
	// ------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			out_last  <= 1'b0;
		end else if (load_en) begin
			out_valid <= head_valid;
			out_last  <= gather_fire && gather_last;
		end
	end

	always_ff @(posedge clk) begin
		if (gather_fire) begin
			out_data <= head_data;
		end
	end

endmodule

`default_nettype wire

/* verilog/scale_gather_top.sv */
// line scaling engine
// scatter, parallel gain lanes, gather
`timescale 1ns/1ps
`default_nettype none

module scale_gather_top import gather_pkg::*, lane_pkg::*; (
	input  logic                  clk,
	input  logic                  reset,
	input  logic [DATA_WIDTH-1:0] in_data,
	input  logic                  in_valid,
	output logic                  in_ready,
	input  logic [GAIN_WIDTH-1:0] gain,
	output logic [DATA_WIDTH-1:0] out_data,
	output logic                  out_valid,
	output logic                  out_last,
	input  logic                  out_ready
);

	logic [SEL_WIDTH-1:0]           scatter_sel;
	logic [SEL_WIDTH-1:0]           gather_sel;
	logic                           gather_last;
	logic                           in_fire;
	logic                           gather_fire;

	logic [DATA_WIDTH-1:0]          lane_in_data;
	logic [PORT_NUM-1:0]            lane_in_valid;
	logic [PORT_NUM-1:0]            lane_in_ready;

	logic [PORT_NUM*DATA_WIDTH-1:0] mult_data;
	logic [PORT_NUM-1:0]            mult_valid;
	logic [PORT_NUM-1:0]            mult_ready;

	logic [PORT_NUM*DATA_WIDTH-1:0] fifo_data;
	logic [PORT_NUM-1:0]            fifo_valid;
	logic [PORT_NUM-1:0]            fifo_ready;

	line_ctrl u_line_ctrl (
		.clk         (clk),
		.reset       (reset),
		.in_fire     (in_fire),
		.gather_fire (gather_fire),
		.scatter_sel (scatter_sel),
		.gather_sel  (gather_sel),
		.gather_last (gather_last)
	);

	line_scatter u_line_scatter (
		.in_data       (in_data),
		.in_valid      (in_valid),
		.in_ready      (in_ready),
		.in_fire       (in_fire),
		.scatter_sel   (scatter_sel),
		.lane_in_data  (lane_in_data),
		.lane_in_valid (lane_in_valid),
		.lane_in_ready (lane_in_ready)
	);

	// ------------------------------------------------------------------
	// lanes
	// ------------------------------------------------------------------
	for (genvar i = 0; i < PORT_NUM; i++) begin : g_lane
		lane_mult u_lane_mult (
			.clk       (clk),
			.reset     (reset),
			.in_data   (lane_in_data),
			.in_valid  (lane_in_valid[i]),
			.gain      (gain),
			.in_ready  (lane_in_ready[i]),
			.out_data  (mult_data[i*DATA_WIDTH +: DATA_WIDTH]),
			.out_valid (mult_valid[i]),
			.out_ready (mult_ready[i])
		);

		lane_fifo u_lane_fifo (
			.clk       (clk),
			.reset     (reset),
			.in_data   (mult_data[i*DATA_WIDTH +: DATA_WIDTH]),
			.in_valid  (mult_valid[i]),
			.in_ready  (mult_ready[i]),
			.out_data  (fifo_data[i*DATA_WIDTH +: DATA_WIDTH]),
			.out_valid (fifo_valid[i]),
			.out_ready (fifo_ready[i])
		);
	end

	data_gather u_data_gather (
		.clk         (clk),
		.reset       (reset),
		.fifo_data   (fifo_data),
		.fifo_valid  (fifo_valid),
		.fifo_ready  (fifo_ready),
		.gather_sel  (gather_sel),
		.gather_last (gather_last),
		.gather_fire (gather_fire),
		.out_data    (out_data),
		.out_valid   (out_valid),
		.out_last    (out_last),
		.out_ready   (out_ready)
	);

endmodule

`default_nettype wire

/* sim/scale_gather_props.sv */
// port assertions for the scaling engine
`timescale 1ns/1ps
`default_nettype none

module scale_gather_props import gather_pkg::*; (
	input logic                  clk,
	input logic                  reset,
	input logic                  in_ready,
	input logic [DATA_WIDTH-1:0] out_data,
	input logic                  out_valid,
	input logic                  out_last,
	input logic                  out_ready
);

	int fail_count = 0;

	// output word held while the sink stalls
	a_out_hold : assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
	else begin
		$error("output word changed or dropped while out_ready was low");
		fail_count++;
	end

	// clean output stage after any reset cycle
	a_reset_state : assert property (@(posedge clk)
		reset |=> !out_valid && !out_last)
	else begin
		$error("out_valid or out_last high after a reset cycle");
		fail_count++;
	end

	a_known : assert property (@(posedge clk) disable iff (reset)
		!$isunknown({out_valid, out_last, in_ready}))
	else begin
		$error("handshake signal unknown out of reset");
		fail_count++;
	end

endmodule

bind scale_gather_top scale_gather_props u_scale_gather_props (
	.clk       (clk),
	.reset     (reset),
	.in_ready  (in_ready),
	.out_data  (out_data),
	.out_valid (out_valid),
	.out_last  (out_last),
	.out_ready (out_ready)
);

`default_nettype wire

/* sim/tb_scale_gather.sv */
// scaling engine testbench
`timescale 1ns/1ps
`default_nettype none

module tb_scale_gather import gather_pkg::*, lane_pkg::*; ();

	localparam int HALF_PERIOD   = 20;
	localparam int SAMPLE_DELAY  = 10;
	localparam int WAIT_LIMIT    = 400;
	localparam int DRAIN_LIMIT   = 2000;
	localparam int STALL_CYCLES  = 60;
	// multipliers, FIFOs and the output register
	localparam int PIPE_CAPACITY = PORT_NUM * (FIFO_DEPTH + 1) + 1;

	logic                  clk = 1'b0;
	logic                  reset;
	logic [DATA_WIDTH-1:0] in_data;
	logic                  in_valid;
	logic                  in_ready;
	logic [GAIN_WIDTH-1:0] gain;
	logic [DATA_WIDTH-1:0] out_data;
	logic                  out_valid;
	logic                  out_last;
	logic                  out_ready;

	// 0 held low, 1 held high, 2 random
	int                    ready_mode;
	int                    seed;
	string                 test_name;
	logic [DATA_WIDTH-1:0] expect_queue [$];
	int                    in_count;
	int                    out_count;
	logic                  saw_in_stall;

	scale_gather_top u_scale_gather_top (
		.clk       (clk),
		.reset     (reset),
		.in_data   (in_data),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.gain      (gain),
		.out_data  (out_data),
		.out_valid (out_valid),
		.out_last  (out_last),
		.out_ready (out_ready)
	);

	always #HALF_PERIOD clk = ~clk;

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	// ------------------------------------------------------------------
	// output ready and monitor
	// ------------------------------------------------------------------
	always @(negedge clk) begin
		out_ready = (ready_mode == 1) || (ready_mode == 2 && ($random(seed) & 1) != 0);
	end

	// sampled mid low phase, so these are the values the next edge sees
	always @(negedge clk) begin
		logic [31:0]           product;
		logic [DATA_WIDTH-1:0] expected;
		logic                  expected_last;
		#SAMPLE_DELAY;
		if (!reset) begin
			assert (u_scale_gather_top.u_scale_gather_props.fail_count == 0)
				else fail_run("a port assertion on the DUT failed");
			if (in_valid && !in_ready) begin
				saw_in_stall = 1'b1;
			end
			if (in_valid && in_ready) begin
				product = in_data * gain;
				expect_queue.push_back(product[DATA_WIDTH-1:0]);
				in_count++;
			end
			if (out_valid && out_ready) begin
				assert (expect_queue.size() != 0)
					else fail_run("output transfer with no pixel outstanding");
				expected      = expect_queue.pop_front();
				expected_last = (out_count % LINE_SIZE) == LINE_SIZE - 1;
				assert (out_data === expected)
					else fail_run($sformatf("Mismatch %s data: expected %h actual %h",
						test_name, expected, out_data));
				assert (out_last === expected_last)
					else fail_run($sformatf("Mismatch %s last: expected %b actual %b",
						test_name, expected_last, out_last));
				out_count++;
			end
			assert (in_count - out_count <= PIPE_CAPACITY)
				else fail_run("more pixels accepted than the pipeline can hold");
		end
	end

	// ------------------------------------------------------------------
	// stimulus tasks
	// ------------------------------------------------------------------
	task automatic set_ready_mode(input int mode);
		@(posedge clk);
		ready_mode = mode;
		@(negedge clk);
	endtask

	task automatic send_pixel(input logic [DATA_WIDTH-1:0] pixel,
		input logic [GAIN_WIDTH-1:0] pixel_gain);
		int waited;
		waited   = 0;
		in_data  = pixel;
		gain     = pixel_gain;
		in_valid = 1'b1;
		#SAMPLE_DELAY;
		while (!in_ready) begin
			waited++;
			if (waited > WAIT_LIMIT) begin
				fail_run("timeout: output stalled, the input never became ready");
			end
			@(negedge clk);
			#SAMPLE_DELAY;
		end
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic send_pixels(input int count, input logic vary_gain);
		int                    i;
		logic [GAIN_WIDTH-1:0] pixel_gain;
		pixel_gain = GAIN_WIDTH'($random(seed)) | GAIN_WIDTH'(1);
		for (i = 0; i < count; i++) begin
			if (vary_gain) begin
				pixel_gain = GAIN_WIDTH'($random(seed));
			end
			send_pixel(DATA_WIDTH'($random(seed)), pixel_gain);
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (expect_queue.size() != 0) begin
			waited++;
			if (waited > DRAIN_LIMIT) begin
				fail_run("timeout: output stalled with pixels still outstanding");
			end
			@(negedge clk);
		end
	endtask

	// ------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------
	initial begin
		int   cycle;
		logic accepted;
		seed         = 12;
		reset        = 1'b1;
		in_data      = '0;
		in_valid     = 1'b0;
		gain         = '0;
		out_ready    = 1'b1;
		ready_mode   = 1;
		in_count     = 0;
		out_count    = 0;
		saw_in_stall = 1'b0;
		test_name    = "reset";
		repeat (3) @(negedge clk);
		reset = 1'b0;

		// order, value and line framing with a free output
		test_name = "order_value";
		send_pixels(6 * LINE_SIZE, 1'b0);
		wait_drain();

		test_name = "back_pressure";
		set_ready_mode(2);
		send_pixels(3 * LINE_SIZE, 1'b0);
		wait_drain();

		// output blocked, input offered every cycle
		test_name = "input_stall";
		set_ready_mode(0);
		saw_in_stall = 1'b0;
		in_data      = DATA_WIDTH'($random(seed));
		gain         = GAIN_WIDTH'($random(seed));
		in_valid     = 1'b1;
		for (cycle = 0; cycle < STALL_CYCLES; cycle++) begin
			#SAMPLE_DELAY;
			accepted = in_ready;
			@(negedge clk);
			if (accepted) begin
				in_data = DATA_WIDTH'($random(seed));
			end
		end
		in_valid = 1'b0;
		assert (saw_in_stall) else fail_run("in_ready never fell while the output was blocked");
		set_ready_mode(1);
		wait_drain();

		// finish the open line, then two more with a new gain per pixel
		test_name = "gain_change";
		send_pixels(LINE_SIZE - (in_count % LINE_SIZE) + 2 * LINE_SIZE, 1'b1);
		wait_drain();

		repeat (4) @(negedge clk);
		if (u_scale_gather_top.u_scale_gather_props.fail_count == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			$display("*** TEST FAILED ***");
			$fatal(1, "a port assertion on the DUT failed");
		end
	end

endmodule

`default_nettype wire

/* build.f */
common/gather_pkg.sv
common/lane_pkg.sv
verilog/line_ctrl.sv
verilog/line_scatter.sv
lane/lane_mult.sv
lane/lane_fifo.sv
verilog/data_gather.sv
verilog/scale_gather_top.sv
sim/scale_gather_props.sv
sim/tb_scale_gather.sv
